//--- list.f
verilog/vec_norm_pkg.sv
verilog/norm_frontend.sv
verilog/inv_sqrt.sv
verilog/lane_scale.sv
verilog/norm_collect.sv
verilog/vec_norm_top.sv
tb/tb_clock_gen.sv
tb/vec_norm_props.sv
tb/vec_norm_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = vec_norm_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "verdict: fail"; exit 1; \
	elif ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "verdict: fail, run ended without a result"; exit 1; \
	else \
		echo "verdict: pass"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/vec_norm_tb.sv
`timescale 1ns/10ps

module vec_norm_tb;
    localparam int LATENCY = vec_norm_pkg::PIPE_LATENCY;
    localparam int N_DIRECTED = 12;
    localparam int N_BURST = 8;
    localparam int N_RANDOM = 300;
    // at most two cycles per vector plus reset and drain times three
    localparam int MAX_CYCLES = 3 * (2 * (N_DIRECTED + N_BURST + N_RANDOM) + 5 + LATENCY);
    localparam real ONE = 16777216.0;  // 2^24
    localparam real DIR_TOL = 1.0e-4;
    localparam real GAIN_MARGIN = 0.01;

    logic                    clk;
    logic                    rst;
    logic                    valid_in;
    logic                    valid_out;
    vec_norm_pkg::vec3_t     vec_in;
    vec_norm_pkg::norm_out_t result;

    vec_norm_pkg::vec3_t sent_q [$];
    vec_norm_pkg::vec3_t sent_vec;
    integer seed;
    int     cycles;
    int     checks;
    int     value_errors;
    int     other_errors;
    int     prop_errors;
    real    gain_lo;
    real    gain_hi;

    tb_clock_gen clock_gen_i (.clk(clk), .rst(rst));

    vec_norm_top #(.LANES(vec_norm_pkg::LANES)) vec_norm_top_i (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .vec_in    (vec_in),
        .valid_out (valid_out),
        .result    (result)
    );

    bind vec_norm_top vec_norm_props vec_norm_props_i (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .vec_in    (vec_in),
        .valid_out (valid_out),
        .result    (result)
    );

    function automatic real to_real(input vec_norm_pkg::fix_t v);
        return $itor(v) / ONE;
    endfunction

    function automatic vec_norm_pkg::fix_t to_fix(input real r);
        return vec_norm_pkg::fix_t'($rtoi(r * ONE));
    endfunction

    function automatic vec_norm_pkg::vec3_t make_vec(input real x, input real y, input real z);
        vec_norm_pkg::vec3_t v;
        v.x = to_fix(x);
        v.y = to_fix(y);
        v.z = to_fix(z);
        return v;
    endfunction

    function automatic vec_norm_pkg::fix_t comp_of(input vec_norm_pkg::vec3_t v, input int i);
        case (i)
            0:       return v.x;
            1:       return v.y;
            default: return v.z;
        endcase
    endfunction

    // output length under the linear fit for n in [0.5, 2)
    task automatic find_gain_bounds();
        real n;
        real g;
        gain_lo = 10.0;
        gain_hi = 0.0;
        for (int i = 0; i < 1536; i++) begin
            n = 0.5 + i / 1024.0;
            g = (1.4142 - 0.275 * n) * $sqrt(n);
            if (g < gain_lo)
                gain_lo = g;
            if (g > gain_hi)
                gain_hi = g;
        end
    endtask

    function automatic vec_norm_pkg::vec3_t rand_vec();
        vec_norm_pkg::vec3_t v;
        real len_sq;
        do begin
            v.x = vec_norm_pkg::fix_t'($random(seed) % 32'sh07E6_6666);  // below 7.9
            v.y = vec_norm_pkg::fix_t'($random(seed) % 32'sh07E6_6666);
            v.z = vec_norm_pkg::fix_t'($random(seed) % 32'sh07E6_6666);
            len_sq = to_real(v.x) * to_real(v.x) + to_real(v.y) * to_real(v.y) +
                     to_real(v.z) * to_real(v.z);
        end while (len_sq < 0.0625);  // keep the squares well above one lsb
        return v;
    endfunction

    task automatic send_vec(input vec_norm_pkg::vec3_t v);
        @(negedge clk);
        valid_in = 1'b1;
        vec_in = v;
        sent_q.push_back(v);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            valid_in = 1'b0;
        end
    endtask

    task automatic check_result(input vec_norm_pkg::vec3_t v, input vec_norm_pkg::norm_out_t r);
        real  c [3];
        real  o [3];
        real  u [3];
        real  len;
        real  s;
        real  diff;
        logic exp_zero;
        logic exp_range;
        exp_zero = 1'b1;
        exp_range = 1'b0;
        len = 0.0;
        s = 0.0;
        for (int i = 0; i < 3; i++) begin
            c[i] = to_real(comp_of(v, i));
            o[i] = to_real(comp_of(r.vec, i));
            if (c[i] != 0.0)
                exp_zero = 1'b0;
            if (c[i] >= 8.0 || c[i] <= -8.0)
                exp_range = 1'b1;
            len = len + c[i] * c[i];
        end
        len = $sqrt(len);
        checks++;
        assert (r.tag.zero == exp_zero && r.tag.range == exp_range) else begin
            value_errors++;
            $display("Error at %0t: flags zero/range expected %b/%b, got %b/%b",
                     $time, exp_zero, exp_range, r.tag.zero, r.tag.range);
        end
        if (exp_zero || exp_range) begin
            assert (r.vec == '0) else begin
                value_errors++;
                $display("Error at %0t: flagged item expected zero components, got %h",
                         $time, r.vec);
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                u[i] = c[i] / len;  // exact unit vector
                s = s + o[i] * u[i];
            end
            assert (s >= gain_lo - GAIN_MARGIN && s <= gain_hi + GAIN_MARGIN) else begin
                value_errors++;
                $display("Error at %0t: output length expected %f to %f, got %f",
                         $time, gain_lo, gain_hi, s);
            end
            for (int i = 0; i < 3; i++) begin
                diff = o[i] - s * u[i];
                assert (diff <= DIR_TOL && diff >= -DIR_TOL) else begin
                    value_errors++;
                    $display("Error at %0t: component %0d expected %f, got %f",
                             $time, i, s * u[i], o[i]);
                end
            end
        end
    endtask

    // outputs are registered so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst && valid_out) begin
            if (sent_q.size() == 0) begin
                other_errors++;
                $display("valid_out was high at %0t with no vector in flight", $time);
            end else begin
                sent_vec = sent_q.pop_front();
                check_result(sent_vec, result);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        valid_in = 1'b0;
        vec_in = '0;
        seed = 32'hb216;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        prop_errors = 0;
        find_gain_bounds();
        wait (rst === 1'b1);

        send_vec(make_vec(3.0, 0.0, 0.0));
        idle(1);
        send_vec(make_vec(0.0, -0.25, 0.0));
        idle(1);
        send_vec(make_vec(0.0, 0.0, 5.5));
        idle(2);
        send_vec(make_vec(-7.5, 0.0, 0.0));
        send_vec(make_vec(1.0, 1.0, 1.0));
        send_vec(make_vec(0.0, 0.0, 0.0));
        idle(1);
        send_vec(make_vec(8.0, 1.0, 0.0));
        send_vec(make_vec(0.0, -8.0, 0.0));
        send_vec(make_vec(0.0, 0.0, 0.0));
        send_vec({32'sh8000_0000, 32'sh0000_0000, 32'sh0100_0000});  // x = -128
        send_vec(make_vec(7.999, -7.999, 7.999));  // largest in-range length
        idle(1);
        send_vec(make_vec(-0.5, 0.75, -2.0));
        idle(3);

        for (int i = 0; i < N_BURST; i++)
            send_vec(rand_vec());
        idle(2);

        for (int i = 0; i < N_RANDOM; i++) begin
            send_vec(rand_vec());
            if ($random(seed) & 1)
                idle(1);
        end
        idle(1);

        while (sent_q.size() != 0)
            @(negedge clk);
        idle(2);

        prop_errors = vec_norm_top_i.vec_norm_props_i.fails;
        $display("checks %0d, value errors %0d, other errors %0d, property errors %0d",
                 checks, value_errors, other_errors, prop_errors);
        if (value_errors == 0 && other_errors == 0 && prop_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tb/vec_norm_props.sv
`timescale 1ns/10ps

module vec_norm_props #(
    parameter int LATENCY = vec_norm_pkg::PIPE_LATENCY
) (
    input logic                    clk,
    input logic                    rst,
    input logic                    valid_in,
    input vec_norm_pkg::vec3_t     vec_in,
    input logic                    valid_out,
    input vec_norm_pkg::norm_out_t result
);
    logic       range_in;
    logic       zero_in;
    logic [3:0] since_rst;  // saturating count of cycles since reset release
    int         fails = 0;  // failed assertions so far

    // flag rule on the input side
    always_comb begin
        zero_in = (vec_in == '0);
        range_in = vec_in.x >= 32'sh0800_0000 || vec_in.x <= -32'sh0800_0000 ||
                   vec_in.y >= 32'sh0800_0000 || vec_in.y <= -32'sh0800_0000 ||
                   vec_in.z >= 32'sh0800_0000 || vec_in.z <= -32'sh0800_0000;
    end

    always_ff @(posedge clk) begin
        if (!rst)
            since_rst <= '0;
        else if (since_rst != '1)
            since_rst <= since_rst + 4'd1;
    end

    a_latency: assert property (@(posedge clk) disable iff (!rst)
        valid_in |-> ##LATENCY valid_out)
        else begin
            $error("valid_out missing %0d cycles after valid_in", LATENCY);
            fails++;
        end

    a_no_extra: assert property (@(posedge clk) disable iff (!rst)
        valid_out |-> $past(valid_in, LATENCY))
        else begin
            $error("valid_out without a matching valid_in");
            fails++;
        end

    a_reset_low: assert property (@(posedge clk) !rst |=> !valid_out)
        else begin
            $error("valid_out high during reset");
            fails++;
        end

    a_after_reset: assert property (@(posedge clk)
        (rst && since_rst < LATENCY) |-> !valid_out)
        else begin
            $error("valid_out high too soon after reset");
            fails++;
        end

    a_range_flag: assert property (@(posedge clk) disable iff (!rst)
        valid_out |-> result.tag.range == $past(range_in, LATENCY))
        else begin
            $error("range flag does not follow the input");
            fails++;
        end

    a_zero_flag: assert property (@(posedge clk) disable iff (!rst)
        valid_out |-> result.tag.zero == $past(zero_in, LATENCY))
        else begin
            $error("zero flag does not follow the input");
            fails++;
        end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 50,  // 100 ns clock
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // active low, released on a falling edge like the other inputs
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

//--- verilog/vec_norm_top.sv
`timescale 1ns/10ps

module vec_norm_top #(
    parameter int LANES = vec_norm_pkg::LANES
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_in,
    input  vec_norm_pkg::vec3_t     vec_in,
    output logic                    valid_out,
    output vec_norm_pkg::norm_out_t result
);
    localparam int W = $bits(vec_norm_pkg::fix_t);

    logic                    mag_valid;
    vec_norm_pkg::ufix_t     mag_sq;
    vec_norm_pkg::vec3_t     dly_vec;
    vec_norm_pkg::norm_tag_t dly_tag;
    logic                    isr_valid;
    vec_norm_pkg::ufix_t     isr;
    logic                    lane_valid;
    vec_norm_pkg::fix_t      lane_out [LANES];

    norm_frontend #(.LANES(LANES)) norm_frontend_i (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .vec_in    (vec_in),
        .mag_valid (mag_valid),
        .mag_sq    (mag_sq),
        .dly_vec   (dly_vec),
        .dly_tag   (dly_tag)
    );

    inv_sqrt #(.WIDTH($bits(vec_norm_pkg::ufix_t))) inv_sqrt_i (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (mag_valid),
        .x         (mag_sq),
        .valid_out (isr_valid),
        .inv_sqrt  (isr)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        if (i == 0) begin : g_first  // lane 0 carries the valid strobe on
            lane_scale lane_scale_i (
                .clk       (clk),
                .rst       (rst),
                .valid_in  (isr_valid),
                .comp      (dly_vec[(LANES-1-i)*W +: W]),
                .isr       (isr),
                .valid_out (lane_valid),
                .comp_out  (lane_out[i])
            );
        end else begin : g_rest
            lane_scale lane_scale_i (
                .clk       (clk),
                .rst       (rst),
                .valid_in  (isr_valid),
                .comp      (dly_vec[(LANES-1-i)*W +: W]),
                .isr       (isr),
                .valid_out (),
                .comp_out  (lane_out[i])
            );
        end
    end

    norm_collect #(.LANES(LANES)) norm_collect_i (
        .lane_valid (lane_valid),
        .lane_out   (lane_out),
        .tag        (dly_tag),
        .valid_out  (valid_out),
        .result     (result)
    );

endmodule

//--- verilog/norm_collect.sv
`timescale 1ns/10ps

module norm_collect #(
    parameter int LANES = 3
) (
    input  logic                    lane_valid,
    input  vec_norm_pkg::fix_t      lane_out [LANES],
    input  vec_norm_pkg::norm_tag_t tag,
    output logic                    valid_out,
    output vec_norm_pkg::norm_out_t result
);
    localparam int W = $bits(vec_norm_pkg::fix_t);

    logic flagged;

    // zero or out-of-range items carry no usable scale factor
    assign flagged = tag.zero | tag.range;

    assign valid_out = lane_valid;

    always_comb begin
        result.tag = tag;
        result.vec = '0;
        for (int i = 0; i < LANES; i++) begin
            if (!flagged)
                result.vec[(LANES-1-i)*W +: W] = lane_out[i];  // lane 0 is x
        end
    end

endmodule

//--- verilog/lane_scale.sv
`timescale 1ns/10ps

module lane_scale (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_in,
    input  vec_norm_pkg::fix_t  comp,
    input  vec_norm_pkg::ufix_t isr,
    output logic                valid_out,
    output vec_norm_pkg::fix_t  comp_out
);
    localparam int W = $bits(vec_norm_pkg::fix_t);

    logic           neg;
    logic [W-1:0]   mag;
    logic [2*W-1:0] prod;
    logic [W-1:0]   scaled;

    // sign-magnitude multiply, isr is unsigned
    assign neg = comp[W-1];
    assign mag = neg ? W'(-comp) : W'(comp);
    assign prod = mag * isr;
    assign scaled = prod[vec_norm_pkg::FRAC_BITS +: W];

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_out <= 1'b0;
            comp_out <= '0;
        end else begin
            valid_out <= valid_in;
            if (valid_in)
                comp_out <= neg ? -$signed(scaled) : $signed(scaled);
        end
    end

endmodule

//--- verilog/inv_sqrt.sv
`timescale 1ns/10ps

module inv_sqrt #(
    parameter int WIDTH = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_in,
    input  vec_norm_pkg::ufix_t x,
    output logic                valid_out,
    output vec_norm_pkg::ufix_t inv_sqrt
);
    localparam int FRAC = vec_norm_pkg::FRAC_BITS;

    // Q8.24 constants
    localparam logic [WIDTH-1:0] FP_HALF = 32'h0080_0000;
    localparam logic [WIDTH-1:0] SQRT2 = 32'h016A_09E6;  // 1.4142
    localparam logic [WIDTH-1:0] SLOPE = 32'h0046_6666;  // 0.275

    int                  lead;
    logic signed [6:0]   shift_k;  // > 0 means x was shifted right
    logic [WIDTH-1:0]    norm_next;
    logic [WIDTH-1:0]    scale_next;

    logic                valid_s1;
    logic [WIDTH-1:0]    norm_x;
    logic [WIDTH-1:0]    scale;

    logic [2*WIDTH-1:0]  slope_prod;
    logic [WIDTH-1:0]    linear;
    logic [2*WIDTH-1:0]  isr_prod;

    // stage 1: leading one, shift count and normalized value in [0.5, 2)
    always_comb begin
        lead = 0;
        for (int i = 0; i < WIDTH; i++) begin
            if (x[i])
                lead = i;  // highest set bit wins
        end

        if (x == '0)
            shift_k = '0;
        else if (lead > FRAC)
            shift_k = 7'(lead - FRAC);
        else if (lead >= FRAC - 1)
            shift_k = '0;  // already in range
        else
            shift_k = 7'(lead - FRAC + 1);

        if (x == '0)
            norm_next = FP_HALF;
        else if (shift_k > 0)
            norm_next = x >> shift_k;
        else
            norm_next = x << (-shift_k);
    end

    // 2^(-k/2) for the current shift count
    always_comb begin
        case (shift_k)
            7'sd7:   scale_next = 32'h0016_A09E;
            7'sd6:   scale_next = 32'h0020_0000;
            7'sd5:   scale_next = 32'h002D_413D;
            7'sd4:   scale_next = 32'h0040_0000;
            7'sd3:   scale_next = 32'h005A_827A;
            7'sd2:   scale_next = 32'h0080_0000;
            7'sd1:   scale_next = 32'h00B5_04F3;
            7'sd0:   scale_next = 32'h0100_0000;
            -7'sd1:  scale_next = 32'h016A_09E6;
            -7'sd2:  scale_next = 32'h0200_0000;
            -7'sd3:  scale_next = 32'h02D4_13CD;
            -7'sd4:  scale_next = 32'h0400_0000;
            -7'sd5:  scale_next = 32'h05A8_279A;
            -7'sd6:  scale_next = 32'h0800_0000;
            -7'sd7:  scale_next = 32'h0B50_4F33;
            -7'sd8:  scale_next = 32'h1000_0000;
            -7'sd9:  scale_next = 32'h16A0_9E67;
            -7'sd10: scale_next = 32'h2000_0000;
            -7'sd11: scale_next = 32'h2D41_3CCD;
            -7'sd12: scale_next = 32'h4000_0000;
            -7'sd13: scale_next = 32'h5A82_799A;
            -7'sd14: scale_next = 32'h8000_0000;
            default: scale_next = 32'hB504_F334;  // -15 and below, saturates
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_s1 <= 1'b0;
            norm_x <= '0;
            scale <= '0;
        end else begin
            valid_s1 <= valid_in;
            if (valid_in) begin
                norm_x <= norm_next;
                scale <= scale_next;
            end
        end
    end

    // stage 2: 1/sqrt(n) ~ 1.4142 - 0.275*n, then rescale
    assign slope_prod = norm_x * SLOPE;
    assign linear = SQRT2 - slope_prod[FRAC +: WIDTH];
    assign isr_prod = linear * scale;

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_out <= 1'b0;
            inv_sqrt <= '0;
        end else begin
            valid_out <= valid_s1;
            if (valid_s1)
                inv_sqrt <= isr_prod[FRAC +: WIDTH];  // keep Q8.24
        end
    end

endmodule

//--- verilog/norm_frontend.sv
`timescale 1ns/10ps

module norm_frontend #(
    parameter int LANES = 3
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_in,
    input  vec_norm_pkg::vec3_t     vec_in,
    output logic                    mag_valid,
    output vec_norm_pkg::ufix_t     mag_sq,
    output vec_norm_pkg::vec3_t     dly_vec,
    output vec_norm_pkg::norm_tag_t dly_tag
);
    localparam int W = $bits(vec_norm_pkg::fix_t);
    localparam int FRAC = vec_norm_pkg::FRAC_BITS;

    // vector meets isr at the lanes, the tag meets the lane outputs
    localparam int VEC_STAGES = vec_norm_pkg::INV_SQRT_LATENCY + 1;
    localparam int TAG_STAGES = VEC_STAGES + 1;

    vec_norm_pkg::fix_t      comp [LANES];
    logic signed [2*W-1:0]   sq_full [LANES];
    vec_norm_pkg::ufix_t     sum_sq;
    vec_norm_pkg::norm_tag_t tag_in;

    vec_norm_pkg::vec3_t     [VEC_STAGES-1:0] vec_dly;
    vec_norm_pkg::norm_tag_t [TAG_STAGES-1:0] tag_dly;

    always_comb begin
        sum_sq = '0;
        tag_in.zero = 1'b1;
        tag_in.range = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            comp[i] = vec_in[(LANES-1-i)*W +: W];
            sq_full[i] = comp[i] * comp[i];  // Q16.48
            sum_sq = sum_sq + sq_full[i][FRAC +: W];  // back to Q8.24
            if (comp[i] != '0)
                tag_in.zero = 1'b0;
            if (comp[i] >= vec_norm_pkg::RANGE_LIMIT || comp[i] <= -vec_norm_pkg::RANGE_LIMIT)
                tag_in.range = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            mag_valid <= 1'b0;
            mag_sq <= '0;
            vec_dly <= '0;
            tag_dly <= '0;
        end else begin
            mag_valid <= valid_in;
            mag_sq <= tag_in.range ? '0 : sum_sq;  // the squares may have wrapped
            vec_dly <= {vec_dly[VEC_STAGES-2:0], vec_in};
            tag_dly <= {tag_dly[TAG_STAGES-2:0], tag_in};
        end
    end

    assign dly_vec = vec_dly[VEC_STAGES-1];
    assign dly_tag = tag_dly[TAG_STAGES-1];

endmodule

//--- verilog/vec_norm_pkg.sv
package vec_norm_pkg;

    // Q8.24 fixed point, 8 integer bits and 24 fraction bits
    typedef logic signed [31:0] fix_t;
    typedef logic [31:0] ufix_t;  // magnitude squared, inverse square root

    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
    } vec3_t;  // x sits in the top word, lane 0

    typedef struct packed {
        logic zero;   // every component is zero
        logic range;  // a component reached +-8.0
    } norm_tag_t;

    typedef struct packed {
        vec3_t     vec;
        norm_tag_t tag;
    } norm_out_t;

    parameter int LANES = 3;
    parameter int FRAC_BITS = 24;

    // components at or beyond this magnitude are not normalized
    parameter fix_t RANGE_LIMIT = 32'sh0800_0000;  // 8.0

    parameter int INV_SQRT_LATENCY = 2;

    // frontend (1) + inv_sqrt (2) + lane (1), the collector adds nothing
    parameter int PIPE_LATENCY = 4;

endpackage
